/* riscv_ex.f */
riscv_ex_pkg.sv
riscv_ex_if.sv
riscv_mux.sv
riscv_id_opt.sv
riscv_imm_gen.sv
riscv_regfile.sv
riscv_alu.sv
riscv_decode_stage.sv
riscv_exec_stage.sv
riscv_ex_top.sv
riscv_ex_tb.sv

/* Makefile */
# Verilator build and run for riscv_ex

VERILATOR ?= verilator
TOP       ?= riscv_ex_tb
FILELIST  ?= riscv_ex.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

/* riscv_ex_tb.sv */
`timescale 1ns/10ps
module riscv_ex_tb;
    import riscv_ex_pkg::*;

    // one expected result per strobe
    typedef struct packed {
        logic        wb_v;
        logic [4:0]  rd;
        logic [31:0] wb_data;
        logic        br_v;
        logic [31:0] br_tgt;
        logic        mem_v;
        lsu_opt_t    lsu;
        logic [2:0]  f3;
        logic [31:0] addr;
        logic [31:0] wdata;     // compared for stores only
    } expect_t;

    logic        clk = 1'b0;
    logic        reset, instr_valid;
    logic [31:0] instr, pc;
    logic        wb_valid, branch_taken, mem_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data, branch_target, mem_addr, mem_wdata;
    lsu_opt_t    mem_lsu_opt;
    logic [2:0]  mem_funct3;

    expect_t     exp0 = '0, exp1 = '0, exp2 = '0;  // exp2 lines up with the outputs
    logic [31:0] shadow [0:31];                    // model regfile where x0 is never written
    logic        check_en = 1'b0;
    integer      seed = 33459;
    int          pulses_expected = 0;
    int          pulses_seen = 0;
    logic [31:0] next_pc = 32'h0000_1000;

    riscv_ex_top dut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        exp1     <= exp0;
        exp2     <= exp1;
        check_en <= 1'b1;   // outputs out of reset after the first edge
    end

    always @(negedge clk) begin
        pulses_seen <= pulses_seen + int'(wb_valid) + int'(branch_taken) + int'(mem_valid);
    end

    task automatic stop_on_error();
        $display("TEST FAILED");
        $fatal(1, "output check failed");
    endtask

    // outputs compared mid-cycle
    wb_check: assert property (@(negedge clk) disable iff (!check_en)
        wb_valid == exp2.wb_v && (!exp2.wb_v || (wb_rd == exp2.rd && wb_data == exp2.wb_data)))
        else begin
            $display("Error: %0t writeback got v=%0b x%0d=%h, expected v=%0b x%0d=%h",
                     $time, wb_valid, wb_rd, wb_data, exp2.wb_v, exp2.rd, exp2.wb_data);
            stop_on_error();
        end

    br_check: assert property (@(negedge clk) disable iff (!check_en)
        branch_taken == exp2.br_v && (!exp2.br_v || branch_target == exp2.br_tgt))
        else begin
            $display("Error: %0t branch got taken=%0b target=%h, expected taken=%0b target=%h",
                     $time, branch_taken, branch_target, exp2.br_v, exp2.br_tgt);
            stop_on_error();
        end

    mem_check: assert property (@(negedge clk) disable iff (!check_en)
        mem_valid == exp2.mem_v && (!exp2.mem_v || (mem_lsu_opt == exp2.lsu &&
        mem_funct3 == exp2.f3 && mem_addr == exp2.addr &&
        (exp2.lsu != lsu_store || mem_wdata == exp2.wdata))))
        else begin
            $display("Error: %0t mem got v=%0b cls=%0d f3=%0d addr=%h wdata=%h, expected v=%0b",
                     $time, mem_valid, mem_lsu_opt, mem_funct3, mem_addr, mem_wdata, exp2.mem_v);
            $display("Error: %0t mem expected cls=%0d f3=%0d addr=%h wdata=%h",
                     $time, exp2.lsu, exp2.f3, exp2.addr, exp2.wdata);
            stop_on_error();
        end

    // rv32i reference evaluated at issue from the shadow registers
    function automatic expect_t predict(input logic [31:0] i, input logic [31:0] p);
        expect_t     e;
        logic [31:0] a, b, imm_i, imm_s, imm_b, imm_u, imm_j, res;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        wr, tk;
        e     = '0;
        f3    = i[14:12];
        f7    = i[31:25];       // also imm[11:5] for shift immediates
        a     = shadow[i[19:15]];
        b     = shadow[i[24:20]];
        imm_i = {{20{i[31]}}, i[31:20]};
        imm_s = {{20{i[31]}}, i[31:25], i[11:7]};
        imm_b = {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
        imm_u = {i[31:12], 12'h000};
        imm_j = {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
        res   = '0;
        wr    = 1'b0;
        tk    = 1'b0;
        case (i[6:0])
            op_op, op_op_imm: begin
                wr = 1'b1;
                if (i[6:0] == op_op_imm) b = imm_i;
                case (f3)
                    3'd0: begin
                        if (i[6:0] == op_op_imm || f7 == 7'h00) res = a + b;
                        else if (f7 == 7'h20)                   res = a - b;
                    end
                    3'd1: res = a << b[4:0];
                    3'd2: res = {31'b0, $signed(a) < $signed(b)};
                    3'd3: res = {31'b0, a < b};
                    3'd4: res = a ^ b;
                    3'd5: begin
                        if (f7 == 7'h00)      res = a >> b[4:0];
                        else if (f7 == 7'h20) res = $signed(a) >>> b[4:0];
                    end
                    3'd6: res = a | b;
                    default: res = a & b;
                endcase
            end
            op_lui:   begin wr = 1'b1; res = imm_u;     end
            op_auipc: begin wr = 1'b1; res = p + imm_u; end
            op_jal: begin
                wr       = 1'b1;
                res      = p + 32'd4;   // link
                e.br_v   = 1'b1;
                e.br_tgt = p + imm_j;
            end
            op_jalr: begin
                wr       = 1'b1;
                res      = p + 32'd4;
                e.br_v   = 1'b1;
                e.br_tgt = (a + imm_i) & 32'hffff_fffe;
            end
            op_branch: begin
                case (f3)
                    3'd0:    tk = (a == b);
                    3'd1:    tk = (a != b);
                    3'd4:    tk = ($signed(a) < $signed(b));
                    3'd5:    tk = ($signed(a) >= $signed(b));
                    3'd6:    tk = (a < b);
                    3'd7:    tk = (a >= b);
                    default: tk = 1'b0;
                endcase
                e.br_v   = tk;
                e.br_tgt = p + imm_b;
            end
            op_load:  begin e.mem_v = 1'b1; e.lsu = lsu_load;  e.addr = a + imm_i; end
            op_store: begin e.mem_v = 1'b1; e.lsu = lsu_store; e.addr = a + imm_s; end
            default: ;          // fence, system and unknown opcodes do nothing
        endcase
        e.f3      = f3;
        e.wdata   = b;
        e.wb_v    = wr && (i[11:7] != 5'd0);
        e.rd      = i[11:7];
        e.wb_data = res;
        return e;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, op_op};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                           input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                           input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    // shadow updated at issue like the bypass
    task automatic issue(input logic [31:0] i);
        expect_t e;
        e = predict(i, next_pc);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= i;
        pc          <= next_pc;
        exp0        <= e;
        if (e.wb_v) shadow[e.rd] = e.wb_data;
        pulses_expected += int'(e.wb_v) + int'(e.br_v) + int'(e.mem_v);
        next_pc = next_pc + 32'd4;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            instr_valid <= 1'b0;
            instr       <= $random(seed);   // junk payload must stay invisible
            pc          <= $random(seed);
            exp0        <= '0;
        end
    endtask

    // lui+addi pair back to back on the same rd
    task automatic load_reg(input logic [4:0] r, input logic [31:0] val);
        issue({val[31:12] + {19'b0, val[11]}, r, op_lui});
        issue(i_type(val[11:0], r, 3'd0, r, op_op_imm));
    endtask

    initial begin
        logic [31:0] r;
        logic [11:0] imm;
        logic [6:0]  f7;
        int          k, j;
        reset       <= 1'b1;
        instr_valid <= 1'b0;
        instr       <= '0;
        pc          <= '0;
        for (k = 0; k < 32; k++) shadow[k] = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        idle(3);                            // quiet outputs after reset
        for (k = 1; k < 32; k++) load_reg(5'(k), $random(seed));
        load_reg(5'd1, 32'h8000_0000);
        load_reg(5'd2, 32'h7fff_ffff);
        load_reg(5'd3, 32'hffff_ffff);
        load_reg(5'd4, 32'd31);
        // signed corners and the invalid funct7
        issue(r_type(7'h00, 5'd2, 5'd1, 3'd2, 5'd10));  // slt
        issue(r_type(7'h00, 5'd2, 5'd1, 3'd3, 5'd11));  // sltu
        issue(r_type(7'h20, 5'd4, 5'd1, 3'd5, 5'd12));  // sra by 31
        issue(r_type(7'h00, 5'd4, 5'd1, 3'd5, 5'd13));  // srl by 31
        issue(r_type(7'h20, 5'd3, 5'd2, 3'd0, 5'd14));  // sub
        issue(r_type(7'h01, 5'd2, 5'd1, 3'd0, 5'd15));  // bad funct7 gives 0
        issue(r_type(7'h01, 5'd4, 5'd1, 3'd5, 5'd16));
        issue(i_type(12'hfff, 5'd1, 3'd2, 5'd17, op_op_imm));   // slti -1
        issue(i_type(12'hfff, 5'd2, 3'd3, 5'd18, op_op_imm));   // sltiu all ones
        issue(i_type({7'h20, 5'd4}, 5'd1, 3'd5, 5'd19, op_op_imm));
        idle(2);
        for (k = 0; k < 48; k++) begin
            r  = $random(seed);
            f7 = (r[2:0] == 3'd0 || r[2:0] == 3'd5) && r[3] ? 7'h20 : 7'h00;
            issue(r_type(f7, r[12:8], r[17:13], r[2:0], r[22:18]));
            r   = $random(seed);
            imm = r[31:20];
            if (r[14:12] == 3'd1) imm[11:5] = 7'h00;
            if (r[14:12] == 3'd5) imm[11:5] = r[3] ? 7'h20 : (r[4] ? 7'h01 : 7'h00);
            issue(i_type(imm, r[19:15], r[14:12], r[11:7], op_op_imm));
        end
        // dependency chain through the bypass with x0 untouched
        issue(i_type(12'd7, 5'd0, 3'd0, 5'd5, op_op_imm));
        issue(r_type(7'h00, 5'd5, 5'd5, 3'd0, 5'd6));
        issue(r_type(7'h20, 5'd5, 5'd6, 3'd0, 5'd7));
        issue(r_type(7'h00, 5'd6, 5'd7, 3'd4, 5'd8));
        issue(r_type(7'h00, 5'd5, 5'd8, 3'd1, 5'd9));
        issue(i_type(12'd1, 5'd9, 3'd0, 5'd0, op_op_imm));      // no writeback
        issue(r_type(7'h00, 5'd9, 5'd0, 3'd0, 5'd20));          // x0 reads 0
        // upper immediates and jumps
        issue({20'habcde, 5'd22, op_lui});
        issue({20'h80001, 5'd23, op_auipc});
        r = $random(seed);
        issue(j_type({r[20:1], 1'b0}, 5'd24));
        issue(i_type(12'h123, 5'd24, 3'd0, 5'd26, op_jalr));    // odd target
        issue(j_type({r[31:12], 1'b0}, 5'd0));
        issue(i_type(12'hffd, 5'd3, 3'd0, 5'd0, op_jalr));
        idle(2);
        load_reg(5'd1, 32'h8000_0000);
        load_reg(5'd2, 32'h7fff_ffff);
        load_reg(5'd3, 32'hffff_ffff);
        load_reg(5'd4, 32'd31);
        for (k = 0; k < 6; k++) begin
            for (j = 0; j < 4; j++) begin
                r = $random(seed);
                issue(b_type({r[12:1], 1'b0}, 5'(j < 2 ? j + 1 : 4), 5'(j == 0 ? 1 : j),
                             3'(k < 2 ? k : k + 2)));
            end
        end
        for (k = 0; k < 12; k++) begin
            r = $random(seed);
            issue(i_type(r[31:20], r[19:15], r[14:12], r[11:7], op_load));
            r = $random(seed);
            issue(s_type(r[31:20], r[24:20], r[19:15], r[14:12]));
        end
        r = $random(seed);
        issue({r[31:7], op_fence});
        issue({r[31:7], op_sys});
        idle(3);                            // sys result is due two edges after its strobe
        for (k = 0; k < 10 && pulses_seen != pulses_expected; k++) @(negedge clk);
        if (pulses_seen == pulses_expected) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("timeout: saw %0d of %0d expected output pulses",
                     pulses_seen, pulses_expected);
            $display("TEST FAILED");
            $fatal(1, "outputs did not drain");
        end
    end

endmodule

/* riscv_ex_top.sv */
`timescale 1ns/10ps
module riscv_ex_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                instr_valid,   // one strobe per instruction
    input  logic [riscv_ex_pkg::xlen-1:0]       instr,
    input  logic [riscv_ex_pkg::xlen-1:0]       pc,
    output logic                                wb_valid,
    output logic [riscv_ex_pkg::reg_addr_w-1:0] wb_rd,
    output logic [riscv_ex_pkg::xlen-1:0]       wb_data,
    output logic                                branch_taken,
    output logic [riscv_ex_pkg::xlen-1:0]       branch_target,
    output logic                                mem_valid,
    output riscv_ex_pkg::lsu_opt_t              mem_lsu_opt,
    output logic [2:0]                          mem_funct3,
    output logic [riscv_ex_pkg::xlen-1:0]       mem_addr,
    output logic [riscv_ex_pkg::xlen-1:0]       mem_wdata
);
    import riscv_ex_pkg::*;

    logic [reg_addr_w-1:0] rs1_addr, rs2_addr, wr_addr;
    logic [xlen-1:0]       rs1_data, rs2_data, wr_data;
    logic                  wr_en;

    riscv_ex_if ex_if ();   // decode -> execute

    riscv_decode_stage u_decode (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .ex          (ex_if.stage_out)
    );

    riscv_regfile u_regfile (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),      // from execute, same cycle
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    riscv_exec_stage u_exec (
        .clk           (clk),
        .reset         (reset),
        .ex            (ex_if.stage_in),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .mem_valid     (mem_valid),
        .mem_lsu_opt   (mem_lsu_opt),
        .mem_funct3    (mem_funct3),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata)
    );

endmodule

/* riscv_exec_stage.sv */
`timescale 1ns/10ps
module riscv_exec_stage (
    input  logic                                clk,
    input  logic                                reset,
    riscv_ex_if.stage_in                        ex,
    output logic                                wr_en,
    output logic [riscv_ex_pkg::reg_addr_w-1:0] wr_addr,
    output logic [riscv_ex_pkg::xlen-1:0]       wr_data,
    output logic                                wb_valid,
    output logic [riscv_ex_pkg::reg_addr_w-1:0] wb_rd,
    output logic [riscv_ex_pkg::xlen-1:0]       wb_data,
    output logic                                branch_taken,
    output logic [riscv_ex_pkg::xlen-1:0]       branch_target,
    output logic                                mem_valid,
    output riscv_ex_pkg::lsu_opt_t              mem_lsu_opt,
    output logic [2:0]                          mem_funct3,
    output logic [riscv_ex_pkg::xlen-1:0]       mem_addr,
    output logic [riscv_ex_pkg::xlen-1:0]       mem_wdata
);
    import riscv_ex_pkg::*;

    logic [xlen-1:0] src_a, src_b, result;
    logic [xlen-1:0] sum;           // pc+imm or rs1+imm
    logic            is_jump, cond, take, writes_rd;

    always_comb begin
        case (ex.src_sel)
            src_pc_imm: begin src_a = ex.pc;       src_b = ex.imm;      end
            src_pc_4:   begin src_a = ex.pc;       src_b = 32'd4;       end  // link
            src_rs1_2:  begin src_a = ex.rs1_data; src_b = ex.rs2_data; end
            default:    begin src_a = ex.rs1_data; src_b = ex.imm;      end
        endcase
    end

    riscv_alu u_alu (
        .alu_opt (ex.alu_opt),
        .src_a   (src_a),
        .src_b   (src_b),
        .result  (result)
    );

    // eq/ne on the difference, the others on the slt bit
    always_comb begin
        case (ex.funct3)
            3'b000:         cond = (result == '0);
            3'b001:         cond = (result != '0);
            3'b100, 3'b110: cond = result[0];
            3'b101, 3'b111: cond = ~result[0];
            default:        cond = 1'b0;
        endcase
    end

    // separate adder, alu is busy with link or compare
    assign sum = ((ex.opcode == op_jalr || ex.lsu_opt != lsu_none) ? ex.rs1_data : ex.pc)
                 + ex.imm;

    assign is_jump   = (ex.opcode == op_jal) || (ex.opcode == op_jalr);
    assign take      = ex.valid && (is_jump || (ex.opcode == op_branch && cond));
    assign writes_rd = ex.opcode inside {op_op, op_op_imm, op_lui, op_auipc, op_jal, op_jalr};

    // regfile write port, lands at the same edge as the outputs
    assign wr_en   = ex.valid && writes_rd && (ex.rd != '0);
    assign wr_addr = ex.rd;
    assign wr_data = result;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid     <= 1'b0;
            branch_taken <= 1'b0;
            mem_valid    <= 1'b0;
        end else begin
            wb_valid     <= wr_en;
            branch_taken <= take;
            mem_valid    <= ex.valid && (ex.lsu_opt != lsu_none);
        end
    end

    always_ff @(posedge clk) begin
        wb_rd         <= ex.rd;
        wb_data       <= result;
        branch_target <= (ex.opcode == op_jalr) ? {sum[xlen-1:1], 1'b0} : sum;
        mem_lsu_opt   <= ex.lsu_opt;
        mem_funct3    <= ex.funct3;    // width and sign for the lsu
        mem_addr      <= sum;
        mem_wdata     <= ex.rs2_data;
    end

endmodule

/* riscv_decode_stage.sv */
`timescale 1ns/10ps
module riscv_decode_stage (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                instr_valid,
    input  logic [riscv_ex_pkg::xlen-1:0]       instr,
    input  logic [riscv_ex_pkg::xlen-1:0]       pc,
    output logic [riscv_ex_pkg::reg_addr_w-1:0] rs1_addr,
    output logic [riscv_ex_pkg::reg_addr_w-1:0] rs2_addr,
    input  logic [riscv_ex_pkg::xlen-1:0]       rs1_data,
    input  logic [riscv_ex_pkg::xlen-1:0]       rs2_data,
    riscv_ex_if.stage_out                       ex
);
    import riscv_ex_pkg::*;

    logic [6:0]      opcode;
    alu_opt_t        alu_opt;
    src_sel_t        src_sel;
    lsu_opt_t        lsu_opt;
    logic [xlen-1:0] imm;

    assign opcode = instr[6:0];

    // lui runs as x0+imm, auipc and jal ignore rs1
    assign rs1_addr = (opcode == op_lui || opcode == op_auipc || opcode == op_jal) ?
                      '0 : instr[19:15];
    assign rs2_addr = instr[24:20];

    riscv_id_opt u_id_opt (
        .opcode  (opcode),
        .funct3  (instr[14:12]),
        .funct7  (instr[31:25]),
        .alu_opt (alu_opt),
        .src_sel (src_sel),
        .lsu_opt (lsu_opt)
    );

    riscv_imm_gen u_imm_gen (
        .instr (instr),
        .imm   (imm)
    );

    always_ff @(posedge clk) begin
        if (reset) ex.valid <= 1'b0;
        else       ex.valid <= instr_valid;
    end

    // payload, qualified by ex.valid downstream
    always_ff @(posedge clk) begin
        ex.pc       <= pc;
        ex.alu_opt  <= alu_opt;
        ex.src_sel  <= src_sel;
        ex.lsu_opt  <= lsu_opt;
        ex.funct3   <= instr[14:12];
        ex.opcode   <= opcode;
        ex.rs1_data <= rs1_data;    // bypassed value if written this cycle
        ex.rs2_data <= rs2_data;
        ex.imm      <= imm;
        ex.rd       <= instr[11:7];
    end

endmodule

/* riscv_alu.sv */
`timescale 1ns/10ps
module riscv_alu (
    input  riscv_ex_pkg::alu_opt_t          alu_opt,
    input  logic [riscv_ex_pkg::xlen-1:0]   src_a,
    input  logic [riscv_ex_pkg::xlen-1:0]   src_b,
    output logic [riscv_ex_pkg::xlen-1:0]   result
);
    import riscv_ex_pkg::*;

    logic [4:0] shamt;      // rv32 shift amount

    assign shamt = src_b[4:0];

    always_comb begin
        case (alu_opt)
            alu_add:  result = src_a + src_b;
            alu_sub:  result = src_a - src_b;           // zero when equal
            alu_sll:  result = src_a << shamt;
            alu_slt:  result = {31'b0, $signed(src_a) < $signed(src_b)};
            alu_sltu: result = {31'b0, src_a < src_b};
            alu_xor:  result = src_a ^ src_b;
            alu_srl:  result = src_a >> shamt;
            alu_sra:  result = $unsigned($signed(src_a) >>> shamt);
            alu_or:   result = src_a | src_b;
            alu_and:  result = src_a & src_b;
            default:  result = '0;                      // alu_none
        endcase
    end

endmodule

/* riscv_regfile.sv */
`timescale 1ns/10ps
module riscv_regfile (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [riscv_ex_pkg::reg_addr_w-1:0] rs1_addr,
    input  logic [riscv_ex_pkg::reg_addr_w-1:0] rs2_addr,
    output logic [riscv_ex_pkg::xlen-1:0]       rs1_data,
    output logic [riscv_ex_pkg::xlen-1:0]       rs2_data,
    input  logic                                wr_en,
    input  logic [riscv_ex_pkg::reg_addr_w-1:0] wr_addr,
    input  logic [riscv_ex_pkg::xlen-1:0]       wr_data
);
    import riscv_ex_pkg::*;

    logic [xlen-1:0] regs [1:31];   // x0 has no storage

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // x0 reads zero, same-cycle write is bypassed
    assign rs1_data = (rs1_addr == '0)                  ? '0      :
                      (wr_en && wr_addr == rs1_addr)    ? wr_data : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0)                  ? '0      :
                      (wr_en && wr_addr == rs2_addr)    ? wr_data : regs[rs2_addr];

endmodule

/* riscv_imm_gen.sv */
`timescale 1ns/10ps
module riscv_imm_gen (
    input  logic [riscv_ex_pkg::xlen-1:0] instr,
    output logic [riscv_ex_pkg::xlen-1:0] imm
);
    import riscv_ex_pkg::*;

    logic sign;     // instr[31] for every format

    assign sign = instr[31];

    always_comb begin
        case (instr[6:0])
            op_op_imm, op_load, op_jalr:    // i-type
                imm = {{20{sign}}, instr[31:20]};
            op_store:                       // s-type
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            op_branch:                      // b-type, bit 0 implied
                imm = {{19{sign}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            op_lui, op_auipc:               // u-type, upper 20
                imm = {instr[31:12], 12'b0};
            op_jal:                         // j-type
                imm = {{11{sign}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            default:
                imm = '0;                   // r-type and others
        endcase
    end

endmodule

/* riscv_id_opt.sv */
`timescale 1ns/10ps
module riscv_id_opt (
    input  logic [6:0]               opcode,
    input  logic [2:0]               funct3,
    input  logic [6:0]               funct7,
    output riscv_ex_pkg::alu_opt_t   alu_opt,
    output riscv_ex_pkg::src_sel_t   src_sel,
    output riscv_ex_pkg::lsu_opt_t   lsu_opt
);
    import riscv_ex_pkg::*;

    always_comb begin
        alu_opt = alu_none;
        case (opcode)
            op_lui, op_auipc, op_jal, op_jalr: alu_opt = alu_add;  // imm, pc+imm, link
            op_branch: begin
                case (funct3)
                    3'b000, 3'b001: alu_opt = alu_sub;     // beq bne, zero test
                    3'b100, 3'b101: alu_opt = alu_slt;     // blt bge
                    3'b110, 3'b111: alu_opt = alu_sltu;    // bltu bgeu
                    default:        alu_opt = alu_none;
                endcase
            end
            op_load, op_store: alu_opt = alu_add;          // address also from own adder
            op_op_imm: begin
                case (funct3)
                    3'b000: alu_opt = alu_add;             // addi
                    3'b010: alu_opt = alu_slt;             // slti
                    3'b011: alu_opt = alu_sltu;            // sltiu
                    3'b100: alu_opt = alu_xor;             // xori
                    3'b110: alu_opt = alu_or;              // ori
                    3'b111: alu_opt = alu_and;             // andi
                    3'b001: alu_opt = alu_sll;             // slli
                    3'b101: begin
                        case (funct7)
                            7'b000_0000: alu_opt = alu_srl;    // srli
                            7'b010_0000: alu_opt = alu_sra;    // srai
                            default:     alu_opt = alu_none;
                        endcase
                    end
                    default: alu_opt = alu_none;
                endcase
            end
            op_op: begin
                case (funct3)
                    3'b000: begin
                        case (funct7)
                            7'b000_0000: alu_opt = alu_add;    // add
                            7'b010_0000: alu_opt = alu_sub;    // sub
                            default:     alu_opt = alu_none;
                        endcase
                    end
                    3'b001: alu_opt = alu_sll;
                    3'b010: alu_opt = alu_slt;
                    3'b011: alu_opt = alu_sltu;
                    3'b100: alu_opt = alu_xor;
                    3'b101: begin
                        case (funct7)
                            7'b000_0000: alu_opt = alu_srl;    // srl
                            7'b010_0000: alu_opt = alu_sra;    // sra
                            default:     alu_opt = alu_none;
                        endcase
                    end
                    3'b110: alu_opt = alu_or;
                    3'b111: alu_opt = alu_and;
                    default: alu_opt = alu_none;
                endcase
            end
            op_fence, op_sys: alu_opt = alu_and;           // result never written
            default: alu_opt = alu_none;
        endcase
    end

    // operand pair per opcode
    riscv_mux #(
        .nr_key  (11),
        .key_len (7),
        .data_t  (src_sel_t)
    ) u_src_sel_mux (
        .key         (opcode),
        .default_out (src_rs1_imm),
        .lut         ({op_lui,    src_rs1_imm,     // rs1 forced to x0
                       op_auipc,  src_pc_imm,
                       op_jal,    src_pc_4,
                       op_jalr,   src_pc_4,
                       op_branch, src_rs1_2,
                       op_load,   src_rs1_imm,
                       op_store,  src_rs1_imm,
                       op_op_imm, src_rs1_imm,
                       op_op,     src_rs1_2,
                       op_fence,  src_rs1_imm,
                       op_sys,    src_rs1_imm}),
        .out         (src_sel)
    );

    // only loads and stores reach the lsu
    riscv_mux #(
        .nr_key  (2),
        .key_len (7),
        .data_t  (lsu_opt_t)
    ) u_lsu_opt_mux (
        .key         (opcode),
        .default_out (lsu_none),
        .lut         ({op_load,  lsu_load,
                       op_store, lsu_store}),
        .out         (lsu_opt)
    );

endmodule

/* riscv_mux.sv */
`timescale 1ns/10ps
module riscv_mux #(
    parameter int  nr_key  = 2,
    parameter int  key_len = 7,
    parameter type data_t  = logic
) (
    input  logic [key_len-1:0]                            key,
    input  data_t                                         default_out,
    input  logic [nr_key-1:0][key_len+$bits(data_t)-1:0]  lut,   // {key, data} per entry
    output data_t                                         out
);

    // linear search, keys are expected unique
    always_comb begin
        out = default_out;      // no hit
        for (int i = 0; i < nr_key; i++) begin
            if (lut[i][key_len+$bits(data_t)-1 -: key_len] == key) begin
                out = data_t'(lut[i][$bits(data_t)-1:0]);   // payload in low bits
            end
        end
    end

endmodule

/* riscv_ex_if.sv */
`timescale 1ns/10ps
interface riscv_ex_if;
    import riscv_ex_pkg::*;

    logic                  valid;      // instruction present in execute
    logic [xlen-1:0]       pc;
    alu_opt_t              alu_opt;
    src_sel_t              src_sel;
    lsu_opt_t              lsu_opt;
    logic [2:0]            funct3;     // branch type, mem width
    logic [6:0]            opcode;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;
    logic [xlen-1:0]       imm;
    logic [reg_addr_w-1:0] rd;

    // decode side
    modport stage_out (
        output valid, pc, alu_opt, src_sel, lsu_opt, funct3, opcode,
        output rs1_data, rs2_data, imm, rd
    );

    // execute side
    modport stage_in (
        input valid, pc, alu_opt, src_sel, lsu_opt, funct3, opcode,
        input rs1_data, rs2_data, imm, rd
    );

endinterface

/* riscv_ex_pkg.sv */
package riscv_ex_pkg;

    localparam int xlen       = 32;     // data path width
    localparam int reg_addr_w = 5;      // x0..x31

    // rv32i base opcodes, instr[6:0]
    localparam logic [6:0] op_lui    = 7'b011_0111;
    localparam logic [6:0] op_auipc  = 7'b001_0111;
    localparam logic [6:0] op_jal    = 7'b110_1111;
    localparam logic [6:0] op_jalr   = 7'b110_0111;
    localparam logic [6:0] op_branch = 7'b110_0011;
    localparam logic [6:0] op_load   = 7'b000_0011;
    localparam logic [6:0] op_store  = 7'b010_0011;
    localparam logic [6:0] op_op_imm = 7'b001_0011;
    localparam logic [6:0] op_op     = 7'b011_0011;
    localparam logic [6:0] op_fence  = 7'b000_1111;   // no-op here
    localparam logic [6:0] op_sys    = 7'b111_0011;   // no-op here

    // alu operation, alu_none gives a zero result
    typedef enum logic [3:0] {
        alu_none = 4'd0,
        alu_add  = 4'd1,
        alu_sub  = 4'd2,
        alu_sll  = 4'd3,
        alu_slt  = 4'd4,
        alu_sltu = 4'd5,
        alu_xor  = 4'd6,
        alu_srl  = 4'd7,
        alu_sra  = 4'd8,
        alu_or   = 4'd9,
        alu_and  = 4'd10
    } alu_opt_t;

    // alu operand pair
    typedef enum logic [1:0] {
        src_rs1_imm = 2'd0,     // a=rs1 b=imm
        src_pc_imm  = 2'd1,     // a=pc  b=imm, auipc
        src_pc_4    = 2'd2,     // a=pc  b=4, link value
        src_rs1_2   = 2'd3      // a=rs1 b=rs2
    } src_sel_t;

    // load/store class handed to the lsu
    typedef enum logic [1:0] {
        lsu_none  = 2'd0,
        lsu_load  = 2'd1,
        lsu_store = 2'd2
    } lsu_opt_t;

endpackage
